//--- common/isa_pkg.sv
package isa_pkg;

  // architectural widths
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_W    = $clog2(NUM_REGS);

  typedef logic [XLEN-1:0]  xlen_t;
  typedef logic [REG_W-1:0] reg_idx_t;

  // x0 is hardwired to zero
  localparam reg_idx_t REG_ZERO = '0;

  // integer operations handled by the execution slice
  typedef enum logic [4:0] {
    NOP   = 5'd0,
    ADD   = 5'd1,
    SUB   = 5'd2,
    AND   = 5'd3,
    OR    = 5'd4,
    XOR   = 5'd5,
    SLL   = 5'd6,
    SRL   = 5'd7,
    SRA   = 5'd8,
    SLT   = 5'd9,
    SLTU  = 5'd10,
    LUI   = 5'd11, // result is the immediate
    AUIPC = 5'd12, // pc + immediate
    JAL   = 5'd13  // link value pc + 4
  } alu_op_e;

  // decoder output, one per dispatch
  typedef struct packed {
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;     // already sign extended / shifted
    logic     use_imm; // second operand comes from imm
    xlen_t    pc;
  } decoded_t;

endpackage

//--- common/rs_pkg.sv
package rs_pkg;

  // tag i+1 belongs to station entry i
  localparam int TAG_W = 4;

  typedef logic [TAG_W-1:0] tag_t;

  // operand is present, nothing to wait for
  localparam tag_t TAG_NONE = '0;

  // one station slot, also the issue payload
  typedef struct packed {
    logic              busy;
    isa_pkg::alu_op_e  op;
    isa_pkg::xlen_t    vj;
    isa_pkg::xlen_t    vk;
    tag_t              qj; // producer of vj, TAG_NONE when vj valid
    tag_t              qk; // producer of vk
    isa_pkg::xlen_t    pc;
  } rs_entry_t;

  // common data bus broadcast
  typedef struct packed {
    logic           valid;
    tag_t           tag;
    isa_pkg::xlen_t value;
  } cdb_t;

endpackage

//--- reservation_station/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
  parameter int RS_ENTRIES = 3
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                dispatch_valid,
  input  isa_pkg::decoded_t   dispatch_inst,
  output logic                dispatch_ready,
  output rs_pkg::tag_t        dispatch_tag,
  output logic                accept,
  output isa_pkg::reg_idx_t   lookup_rs1,
  output isa_pkg::reg_idx_t   lookup_rs2,
  output isa_pkg::reg_idx_t   lookup_rd,
  input  isa_pkg::xlen_t      vj,
  input  isa_pkg::xlen_t      vk,
  input  rs_pkg::tag_t        qj,
  input  rs_pkg::tag_t        qk,
  input  rs_pkg::cdb_t        cdb,
  output logic                issue_valid,
  output rs_pkg::tag_t        issue_tag,
  output rs_pkg::rs_entry_t   issue_entry
);

  localparam int IDX_W = $clog2(RS_ENTRIES);

  rs_pkg::rs_entry_t entries [RS_ENTRIES];
  rs_pkg::rs_entry_t new_entry;

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] ready_idx;
  logic             has_free;
  logic             has_ready;
  logic             no_rs1;

  // lowest free slot for allocation, lowest ready slot for issue
  always_comb begin
    has_free  = 1'b0;
    free_idx  = '0;
    has_ready = 1'b0;
    ready_idx = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (!entries[i].busy) begin
        has_free = 1'b1;
        free_idx = IDX_W'(i);
      end
      if (entries[i].busy && entries[i].qj == rs_pkg::TAG_NONE &&
          entries[i].qk == rs_pkg::TAG_NONE) begin
        has_ready = 1'b1;
        ready_idx = IDX_W'(i);
      end
    end
  end

  assign dispatch_ready = has_free; // only full blocks dispatch
  assign dispatch_tag   = rs_pkg::tag_t'(free_idx) + rs_pkg::tag_t'(1);
  assign accept         = dispatch_valid && has_free;

  assign lookup_rs1 = dispatch_inst.rs1;
  assign lookup_rs2 = dispatch_inst.rs2;
  assign lookup_rd  = dispatch_inst.rd;

  assign no_rs1 = (dispatch_inst.op == isa_pkg::LUI) ||
                  (dispatch_inst.op == isa_pkg::AUIPC) ||
                  (dispatch_inst.op == isa_pkg::JAL);

  // operand substitution at allocation
  always_comb begin
    new_entry.busy = 1'b1;
    new_entry.op   = dispatch_inst.op;
    new_entry.pc   = dispatch_inst.pc;
    if (no_rs1) begin
      new_entry.vj = '0;
      new_entry.qj = rs_pkg::TAG_NONE;
    end else begin
      new_entry.vj = vj;
      new_entry.qj = qj;
    end
    if (dispatch_inst.use_imm) begin
      new_entry.vk = dispatch_inst.imm;
      new_entry.qk = rs_pkg::TAG_NONE;
    end else begin
      new_entry.vk = vk;
      new_entry.qk = qk;
    end
  end

  assign issue_valid = has_ready;
  assign issue_tag   = rs_pkg::tag_t'(ready_idx) + rs_pkg::tag_t'(1);
  assign issue_entry = entries[ready_idx];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < RS_ENTRIES; i++) begin
        entries[i].busy <= 1'b0;
      end
    end else begin
      // wakeup from the broadcast
      if (cdb.valid) begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
          if (entries[i].busy && entries[i].qj == cdb.tag) begin
            entries[i].qj <= rs_pkg::TAG_NONE;
            entries[i].vj <= cdb.value;
          end
          if (entries[i].busy && entries[i].qk == cdb.tag) begin
            entries[i].qk <= rs_pkg::TAG_NONE;
            entries[i].vk <= cdb.value;
          end
        end
      end
      if (accept) begin
        entries[free_idx] <= new_entry; // free slot, never the issuing one
      end
      if (issue_valid) begin
        entries[ready_idx].busy <= 1'b0; // slot reusable next cycle
      end
    end
  end

  a_issue_busy : assert property (@(posedge clk_in) disable iff (rst_in)
    issue_valid |-> issue_entry.busy);

  a_accept_not_full : assert property (@(posedge clk_in) disable iff (rst_in)
    accept |-> !(entries[free_idx].busy));

  // the same-cycle bypass in reg_status must keep a slot off its own tag
  for (genvar g = 0; g < RS_ENTRIES; g++) begin : g_self_tag
    a_no_self_wait : assert property (@(posedge clk_in) disable iff (rst_in)
      entries[g].busy |-> (entries[g].qj != rs_pkg::tag_t'(g + 1) &&
                           entries[g].qk != rs_pkg::tag_t'(g + 1)));
  end

endmodule

//--- reservation_station/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              issue_valid,
  input  rs_pkg::tag_t      issue_tag,
  input  rs_pkg::rs_entry_t issue_entry,
  output rs_pkg::cdb_t      cdb
);

  isa_pkg::xlen_t result;
  isa_pkg::xlen_t op_a;
  isa_pkg::xlen_t op_b;
  logic [4:0]     shamt;

  assign op_a  = issue_entry.vj;
  assign op_b  = issue_entry.vk;
  assign shamt = op_b[4:0]; // RV32 shift amount

  always_comb begin
    case (issue_entry.op)
      isa_pkg::ADD:   result = op_a + op_b;
      isa_pkg::SUB:   result = op_a - op_b;
      isa_pkg::AND:   result = op_a & op_b;
      isa_pkg::OR:    result = op_a | op_b;
      isa_pkg::XOR:   result = op_a ^ op_b;
      isa_pkg::SLL:   result = op_a << shamt;
      isa_pkg::SRL:   result = op_a >> shamt;
      isa_pkg::SRA:   result = isa_pkg::xlen_t'($signed(op_a) >>> shamt);
      isa_pkg::SLT: begin
        result = {31'b0, $signed(op_a) < $signed(op_b)};
      end
      isa_pkg::SLTU:  result = {31'b0, op_a < op_b};
      isa_pkg::LUI:   result = op_b; // imm already in vk
      isa_pkg::AUIPC: result = issue_entry.pc + op_b;
      isa_pkg::JAL:   result = issue_entry.pc + 32'd4;
      default:        result = '0; // NOP
    endcase
  end

  // one result per cycle onto the bus, no stall path
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= issue_valid;
    end
    cdb.tag   <= issue_tag;
    cdb.value <= result;
  end

  a_cdb_tag : assert property (@(posedge clk_in) disable iff (rst_in)
    cdb.valid |-> cdb.tag != rs_pkg::TAG_NONE);

endmodule

//--- logic/reg_status.sv
`timescale 1ns/1ps

module reg_status (
  input  logic              clk_in,
  input  logic              rst_in,
  input  isa_pkg::reg_idx_t rs1,
  input  isa_pkg::reg_idx_t rs2,
  input  isa_pkg::reg_idx_t rd,
  input  logic              accept,
  input  rs_pkg::tag_t      new_tag,
  input  rs_pkg::cdb_t      cdb,
  output isa_pkg::xlen_t    vj,
  output isa_pkg::xlen_t    vk,
  output rs_pkg::tag_t      qj,
  output rs_pkg::tag_t      qk,
  input  isa_pkg::reg_idx_t arch_idx,
  output isa_pkg::xlen_t    arch_data
);

  isa_pkg::xlen_t regs [isa_pkg::NUM_REGS];
  rs_pkg::tag_t   tags [isa_pkg::NUM_REGS]; // pending producer per register

  // operand read with bypass from the broadcast in flight
  function automatic void lookup(
    input  isa_pkg::reg_idx_t idx,
    output isa_pkg::xlen_t    val,
    output rs_pkg::tag_t      tag
  );
    if (idx == isa_pkg::REG_ZERO) begin
      val = '0;
      tag = rs_pkg::TAG_NONE;
    end else if (tags[idx] != rs_pkg::TAG_NONE && cdb.valid && cdb.tag == tags[idx]) begin
      val = cdb.value;
      tag = rs_pkg::TAG_NONE;
    end else begin
      val = regs[idx];
      tag = tags[idx];
    end
  endfunction

  always_comb begin
    lookup(rs1, vj, qj);
    lookup(rs2, vk, qk);
  end

  assign arch_data = regs[arch_idx]; // debug port

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
        tags[i] <= rs_pkg::TAG_NONE;
      end
    end else begin
      // write back only where the tag still names this producer
      if (cdb.valid) begin
        for (int i = 1; i < isa_pkg::NUM_REGS; i++) begin
          if (tags[i] == cdb.tag) begin
            regs[i] <= cdb.value;
            tags[i] <= rs_pkg::TAG_NONE;
          end
        end
      end
      // later assignment, so a fresh rename beats the write back
      if (accept && rd != isa_pkg::REG_ZERO) begin
        tags[rd] <= new_tag;
      end
    end
  end

  a_x0_untagged : assert property (@(posedge clk_in) disable iff (rst_in)
    tags[0] == rs_pkg::TAG_NONE);

endmodule

//--- logic/exec_core.sv
`timescale 1ns/1ps

module exec_core #(
  parameter int RS_ENTRIES = 3
) (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              dispatch_valid,
  input  isa_pkg::decoded_t dispatch_inst,
  output logic              dispatch_ready,
  output rs_pkg::tag_t      dispatch_tag,
  output rs_pkg::cdb_t      cdb,
  input  isa_pkg::reg_idx_t arch_idx,
  output isa_pkg::xlen_t    arch_data
);

  logic              accept;
  isa_pkg::reg_idx_t lookup_rs1;
  isa_pkg::reg_idx_t lookup_rs2;
  isa_pkg::reg_idx_t lookup_rd;
  isa_pkg::xlen_t    vj;
  isa_pkg::xlen_t    vk;
  rs_pkg::tag_t      qj;
  rs_pkg::tag_t      qk;
  logic              issue_valid;
  rs_pkg::tag_t      issue_tag;
  rs_pkg::rs_entry_t issue_entry;

  // operand lookup and destination rename
  reg_status u_reg_status (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rs1       (lookup_rs1),
    .rs2       (lookup_rs2),
    .rd        (lookup_rd),
    .accept    (accept),
    .new_tag   (dispatch_tag),
    .cdb       (cdb),
    .vj        (vj),
    .vk        (vk),
    .qj        (qj),
    .qk        (qk),
    .arch_idx  (arch_idx),
    .arch_data (arch_data)
  );

  reservation_station #(
    .RS_ENTRIES (RS_ENTRIES)
  ) u_rs (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .dispatch_valid (dispatch_valid),
    .dispatch_inst  (dispatch_inst),
    .dispatch_ready (dispatch_ready),
    .dispatch_tag   (dispatch_tag),
    .accept         (accept),
    .lookup_rs1     (lookup_rs1),
    .lookup_rs2     (lookup_rs2),
    .lookup_rd      (lookup_rd),
    .vj             (vj),
    .vk             (vk),
    .qj             (qj),
    .qk             (qk),
    .cdb            (cdb),
    .issue_valid    (issue_valid),
    .issue_tag      (issue_tag),
    .issue_entry    (issue_entry)
  );

  alu u_alu (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .issue_tag   (issue_tag),
    .issue_entry (issue_entry),
    .cdb         (cdb) // drives the whole slice and the outside
  );

endmodule

//--- sim/exec_checker.sv
`timescale 1ns/1ps

module exec_checker #(
  parameter int RS_ENTRIES = 3
) (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              dispatch_valid,
  input  isa_pkg::decoded_t dispatch_inst,
  input  logic              dispatch_ready,
  input  rs_pkg::tag_t      dispatch_tag,
  input  rs_pkg::cdb_t      cdb,
  input  isa_pkg::reg_idx_t arch_idx,
  input  isa_pkg::xlen_t    arch_data,
  input  logic [1:0]        reg_check,  // 1 for reset values and 2 for final model
  input  logic              report_req,
  output int                error_count,
  output int                outstanding
);

  isa_pkg::xlen_t model_regs [32]; // in-order architectural state
  rs_pkg::tag_t   model_tags [32]; // latest in-flight producer per register
  isa_pkg::xlen_t expected [16];
  logic           pending [16];
  logic           dependent [16];

  int   accepted_cnt = 0;
  int   broadcast_cnt = 0;
  int   err_result = 0;
  int   err_dependence = 0;
  int   err_backpressure = 0;
  int   err_reset = 0;
  int   err_final = 0;
  int   err_complete = 0;
  logic rst_q = 1'b0;

  assign outstanding = accepted_cnt - broadcast_cnt;
  assign error_count = err_result + err_dependence + err_backpressure +
                       err_reset + err_final + err_complete;

  // RV32I semantics of each supported op
  function automatic isa_pkg::xlen_t reference_result(
    input isa_pkg::alu_op_e op,
    input isa_pkg::xlen_t   src1,
    input isa_pkg::xlen_t   src2,
    input isa_pkg::xlen_t   imm,
    input logic             use_imm,
    input isa_pkg::xlen_t   pc
  );
    isa_pkg::xlen_t b;
    b = use_imm ? imm : src2;
    case (op)
      isa_pkg::ADD:   return src1 + b;
      isa_pkg::SUB:   return src1 - b;
      isa_pkg::AND:   return src1 & b;
      isa_pkg::OR:    return src1 | b;
      isa_pkg::XOR:   return src1 ^ b;
      isa_pkg::SLL:   return src1 << b[4:0];
      isa_pkg::SRL:   return src1 >> b[4:0];
      isa_pkg::SRA:   return isa_pkg::xlen_t'($signed(src1) >>> b[4:0]);
      isa_pkg::SLT:   return ($signed(src1) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::SLTU:  return (src1 < b) ? 32'd1 : 32'd0;
      isa_pkg::LUI:   return imm;
      isa_pkg::AUIPC: return pc + imm;
      isa_pkg::JAL:   return pc + 32'd4; // link value
      default:        return '0;
    endcase
  endfunction

  function automatic logic reads_rs1(input isa_pkg::alu_op_e op);
    return !(op == isa_pkg::LUI || op == isa_pkg::AUIPC || op == isa_pkg::JAL);
  endfunction

  task automatic show_mismatch(input string test, input string what,
                               input isa_pkg::xlen_t exp, input isa_pkg::xlen_t act);
    $display("FAIL %s: %s expected %h actual %h", test, what, exp, act);
  endtask

  always @(posedge clk_in) begin
    int             in_station;
    logic           took;
    logic           waits;
    isa_pkg::xlen_t value;
    rs_pkg::tag_t   t;
    if (rst_in) begin
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
        model_tags[i] = rs_pkg::TAG_NONE;
      end
      for (int i = 0; i < 16; i++) begin
        pending[i] = 1'b0;
      end
      accepted_cnt  = 0;
      broadcast_cnt = 0;
    end else begin
      if (rst_q) begin // first edge out of reset
        if (dispatch_ready !== 1'b1) begin
          err_reset++;
          show_mismatch("reset", "dispatch_ready", 32'd1, 32'(dispatch_ready));
        end
        if (cdb.valid !== 1'b0) begin
          err_reset++;
          show_mismatch("reset", "cdb.valid", 32'd0, 32'(cdb.valid));
        end
      end
      // the entry on the cdb register already left the station
      in_station = accepted_cnt - broadcast_cnt - int'(cdb.valid);
      if (dispatch_ready != (in_station < RS_ENTRIES)) begin
        err_backpressure++;
        show_mismatch("backpressure", $sformatf("dispatch_ready with %0d busy", in_station),
                      32'(in_station < RS_ENTRIES), 32'(dispatch_ready));
      end
      took  = dispatch_valid && dispatch_ready;
      value = '0;
      waits = 1'b0;
      if (took) begin // operands from the in-order model before this edge's broadcast
        value = reference_result(dispatch_inst.op, model_regs[dispatch_inst.rs1],
                                 model_regs[dispatch_inst.rs2], dispatch_inst.imm,
                                 dispatch_inst.use_imm, dispatch_inst.pc);
        waits = (reads_rs1(dispatch_inst.op) &&
                 model_tags[dispatch_inst.rs1] != rs_pkg::TAG_NONE) ||
                (!dispatch_inst.use_imm && model_tags[dispatch_inst.rs2] != rs_pkg::TAG_NONE);
      end
      if (cdb.valid) begin
        t = cdb.tag;
        if (!pending[t]) begin
          err_complete++;
          $display("complete: broadcast on tag %0d with no instruction in flight", t);
        end else begin
          if (cdb.value != expected[t]) begin
            if (dependent[t]) begin
              err_dependence++;
              show_mismatch("dependence", $sformatf("tag %0d", t), expected[t], cdb.value);
            end else begin
              err_result++;
              show_mismatch("result", $sformatf("tag %0d", t), expected[t], cdb.value);
            end
          end
          pending[t] = 1'b0;
          broadcast_cnt++;
        end
        for (int r = 1; r < 32; r++) begin
          if (model_tags[r] == t) begin
            model_tags[r] = rs_pkg::TAG_NONE;
          end
        end
      end
      if (took) begin
        t = dispatch_tag;
        if (pending[t]) begin
          err_complete++;
          $display("complete: tag %0d handed out again before its broadcast", t);
        end
        expected[t]  = value;
        pending[t]   = 1'b1;
        dependent[t] = waits;
        if (dispatch_inst.rd != isa_pkg::REG_ZERO) begin
          model_regs[dispatch_inst.rd] = value;
          model_tags[dispatch_inst.rd] = t;
        end
        accepted_cnt++;
      end
      if (reg_check == 2'd1 && arch_data != '0) begin
        err_reset++;
        show_mismatch("reset", $sformatf("x%0d", arch_idx), '0, arch_data);
      end
      if (reg_check == 2'd2 && arch_data != model_regs[arch_idx]) begin
        err_final++;
        show_mismatch("final_regs", $sformatf("x%0d", arch_idx), model_regs[arch_idx], arch_data);
      end
      if (report_req) begin
        if (accepted_cnt != broadcast_cnt) begin
          err_complete++;
          $display("complete: %0d accepted instructions never broadcast",
                   accepted_cnt - broadcast_cnt);
        end
        $display({"errors: result=%0d dependence=%0d backpressure=%0d reset=%0d ",
                  "final_regs=%0d complete=%0d"},
                 err_result, err_dependence, err_backpressure, err_reset, err_final,
                 err_complete);
      end
    end
    rst_q = rst_in;
  end

endmodule

//--- sim/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

  localparam int RS_ENTRIES      = 3;
  localparam int NUM_INSTS       = 400;
  localparam int WATCHDOG_CYCLES = NUM_INSTS * 20 + 200;
  localparam int DRAIN_CYCLES    = 100;

  logic              clk_in;
  logic              rst_in;
  logic              dispatch_valid;
  isa_pkg::decoded_t dispatch_inst;
  logic              dispatch_ready;
  rs_pkg::tag_t      dispatch_tag;
  rs_pkg::cdb_t      cdb;
  isa_pkg::reg_idx_t arch_idx;
  isa_pkg::xlen_t    arch_data;
  logic [1:0]        reg_check;
  logic              report_req;
  int                error_count;
  int                outstanding;
  isa_pkg::reg_idx_t recent_rd [4]; // last destinations, source of dependences

  always #50 clk_in = ~clk_in;

  exec_core #(.RS_ENTRIES(RS_ENTRIES)) UUT (
    .clk_in(clk_in), .rst_in(rst_in), .dispatch_valid(dispatch_valid),
    .dispatch_inst(dispatch_inst), .dispatch_ready(dispatch_ready),
    .dispatch_tag(dispatch_tag), .cdb(cdb), .arch_idx(arch_idx), .arch_data(arch_data)
  );

  exec_checker #(.RS_ENTRIES(RS_ENTRIES)) u_checker (
    .clk_in(clk_in), .rst_in(rst_in), .dispatch_valid(dispatch_valid),
    .dispatch_inst(dispatch_inst), .dispatch_ready(dispatch_ready),
    .dispatch_tag(dispatch_tag), .cdb(cdb), .arch_idx(arch_idx), .arch_data(arch_data),
    .reg_check(reg_check), .report_req(report_req), .error_count(error_count),
    .outstanding(outstanding)
  );

  function automatic isa_pkg::reg_idx_t pick_source();
    if ($urandom_range(1) == 0) begin
      return recent_rd[2'($urandom_range(3))];
    end
    return isa_pkg::reg_idx_t'($urandom_range(31));
  endfunction

  function automatic isa_pkg::decoded_t random_inst(input isa_pkg::xlen_t pc);
    isa_pkg::decoded_t inst;
    logic [11:0]       imm12;
    imm12        = 12'($urandom);
    inst.op      = isa_pkg::alu_op_e'(5'($urandom_range(13, 1)));
    inst.rd      = isa_pkg::reg_idx_t'($urandom_range(31));
    inst.rs1     = pick_source();
    inst.rs2     = pick_source();
    inst.pc      = pc;
    inst.use_imm = 1'($urandom_range(1));
    inst.imm     = {{20{imm12[11]}}, imm12}; // I-type sign extension
    if (inst.op == isa_pkg::LUI || inst.op == isa_pkg::AUIPC) begin
      inst.use_imm = 1'b1;
      inst.imm     = {20'($urandom), 12'b0}; // U-type
    end else if (inst.op == isa_pkg::SUB) begin
      inst.use_imm = 1'b0;
    end
    for (int i = 3; i > 0; i--) begin
      recent_rd[i] = recent_rd[i-1];
    end
    recent_rd[0] = inst.rd;
    return inst;
  endfunction

  task automatic read_all_regs(input logic [1:0] mode);
    for (int i = 0; i < 32; i++) begin
      @(posedge clk_in);
      arch_idx  <= isa_pkg::reg_idx_t'(i);
      reg_check <= mode;
    end
    @(posedge clk_in);
    reg_check <= 2'd0;
  endtask

  task automatic send_program();
    int   sent;
    int   made;
    logic holding;
    sent = 0;
    made = 0;
    while (sent < NUM_INSTS) begin
      @(posedge clk_in);
      holding = dispatch_valid && !dispatch_ready; // keep the stalled one
      if (dispatch_valid && dispatch_ready) begin
        sent++;
      end
      if (!holding) begin
        if (made < NUM_INSTS && $urandom_range(3) != 0) begin
          dispatch_inst  <= random_inst(isa_pkg::xlen_t'(32'h1000 + made * 4));
          dispatch_valid <= 1'b1;
          made++;
        end else begin
          dispatch_valid <= 1'b0; // idle cycle
        end
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk_in);
      waited++;
    end
    repeat (2) @(posedge clk_in);
  endtask

  initial begin
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_inst  = '0;
    arch_idx       = '0;
    reg_check      = 2'd0;
    report_req     = 1'b0;
    for (int i = 0; i < 4; i++) begin
      recent_rd[i] = '0;
    end
    void'($urandom(11));
    repeat (5) @(posedge clk_in);
    rst_in <= 1'b0;
    read_all_regs(2'd1);
    send_program();
    drain();
    read_all_regs(2'd2);
    report_req <= 1'b1;
    @(posedge clk_in);
    report_req <= 1'b0;
    @(negedge clk_in);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_in);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- exec_core.f
common/isa_pkg.sv
common/rs_pkg.sv
reservation_station/reservation_station.sv
reservation_station/alu.sv
logic/reg_status.sv
logic/exec_core.sv
sim/exec_checker.sv
sim/tb_exec_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exec_core -f exec_core.f \
  && ./obj_dir/Vtb_exec_core | tee /dev/stderr | grep -q "All checks passed" \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

exit 0
